/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_frame_checker
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/align_fsm.sv */
`include "frame_check_settings.svh"

module align_fsm
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_start,
	input  logic                    i_period_end,
	input  frame_check_pkg::delay_t i_best_delay,
	output frame_check_pkg::delay_t o_cur_delay,
	output logic                    o_searching,
	output logic                    o_locked
);
	import frame_check_pkg::*;

	align_state_t state;
	logic         locked_q;

	// Searching drops for the start cycle, so the timer and tracker see a fresh search.
	assign o_searching = (state == SEARCH) && !i_start;
	assign o_locked    = locked_q;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state       <= IDLE;
			o_cur_delay <= '0;
			locked_q    <= 1'b0;
		end
		else
		begin
			locked_q <= (state == LOCKED) && !i_start;
			if (i_start)
			begin
				state       <= SEARCH;
				o_cur_delay <= '0;
			end
			else
			begin
				case (state)
					SEARCH:
					begin
						if (i_period_end)
						begin
							if (o_cur_delay == delay_t'(`FC_MAX_DELAY - 1))
								state <= LOCKED;
							else
								o_cur_delay <= o_cur_delay + 1'b1;
						end
					end
					LOCKED:
					begin
						// The tracker settles its best delay on the edge that ends the search.
						o_cur_delay <= i_best_delay;
					end
					default:
					begin
						o_cur_delay <= '0;
					end
				endcase
			end
		end
	end

	a_search_lock_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_searching && o_locked));

endmodule

/* hdl/apb_regs.sv */
`include "frame_check_settings.svh"

module apb_regs
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_psel,
	input  logic                    i_penable,
	input  logic                    i_pwrite,
	input  logic [7:0]              i_paddr,
	input  logic [31:0]             i_pwdata,
	output logic [31:0]             o_prdata,
	input  logic                    i_searching,
	input  logic                    i_locked,
	input  frame_check_pkg::delay_t i_best_delay,
	input  frame_check_pkg::err_t   i_min_errors,
	input  frame_check_pkg::err_t   i_lock_errors,
	output logic                    o_start,
	output logic                    o_clear_lock
);

	logic access;
	logic wr_access;

	assign access    = i_psel && i_penable; // Zero wait states, so every access phase completes.
	assign wr_access = access && i_pwrite;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_start      <= 1'b0;
			o_clear_lock <= 1'b0;
		end
		else
		begin
			o_start      <= wr_access && (i_paddr == `FC_ADDR_CONTROL) && i_pwdata[0];
			o_clear_lock <= wr_access && (i_paddr == `FC_ADDR_LOCK_ERRORS);
		end
	end

	// CONTROL reads back as zero.
	always_comb
	begin
		case (i_paddr)
			`FC_ADDR_STATUS:      o_prdata = {30'd0, i_searching, i_locked};
			`FC_ADDR_BEST_DELAY:  o_prdata = 32'(i_best_delay);
			`FC_ADDR_MIN_ERRORS:  o_prdata = 32'(i_min_errors);
			`FC_ADDR_LOCK_ERRORS: o_prdata = 32'(i_lock_errors);
			default:              o_prdata = 32'd0;
		endcase
	end

	a_penable_needs_psel: assert property (@(posedge i_clock) disable iff (i_reset)
		i_penable |-> i_psel);

endmodule

/* hdl/error_tracker.sv */
module error_tracker
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_enable,
	input  logic                    i_searching,
	input  logic                    i_locked,
	input  logic                    i_period_end,
	input  logic                    i_clear_lock,
	input  frame_check_pkg::delay_t i_cur_delay,
	input  frame_check_pkg::data_t  i_rx_data,
	input  frame_check_pkg::data_t  i_tx_delayed_data,
	input  frame_check_pkg::ctrl_t  i_rx_ctrl,
	input  frame_check_pkg::ctrl_t  i_tx_delayed_ctrl,
	output frame_check_pkg::delay_t o_best_delay,
	output frame_check_pkg::err_t   o_min_errors,
	output frame_check_pkg::err_t   o_lock_errors
);
	import frame_check_pkg::*;

	logic mismatch;
	logic searching_q;
	logic search_start;
	err_t period_count;
	err_t period_total;
	err_t min_now;

	assign mismatch     = (i_rx_data != i_tx_delayed_data) || (i_rx_ctrl != i_tx_delayed_ctrl);
	assign search_start = i_searching && !searching_q;
	assign period_total = period_count + err_t'(i_enable && mismatch); // Includes this block.
	assign min_now      = search_start ? '1 : o_min_errors;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			searching_q <= 1'b0;
		else
			searching_q <= i_searching;

		if (i_reset || !i_searching || i_period_end)
			period_count <= '0;
		else
			period_count <= period_total;
	end

	// Strictly lower wins, so a tie keeps the earlier delay.
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			o_best_delay <= '0;
			o_min_errors <= '1;
		end
		else if (i_searching && i_period_end && (period_total < min_now))
		begin
			o_best_delay <= i_cur_delay;
			o_min_errors <= period_total;
		end
		else if (search_start)
			o_min_errors <= '1;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset || i_clear_lock || search_start)
			o_lock_errors <= '0;
		else if (i_locked && i_enable && mismatch && (o_lock_errors != '1))
			o_lock_errors <= o_lock_errors + 1'b1;
	end

endmodule

/* hdl/frame_check_pkg.sv */
package frame_check_pkg;

`include "frame_check_settings.svh"

	// One raw block of the PCS stream.
	typedef logic [63:0] data_t;

	// One control bit per data byte.
	typedef logic [7:0] ctrl_t;

	typedef logic [$clog2(`FC_MAX_DELAY)-1:0] delay_t;

	// Mismatch counts saturate at all ones.
	typedef logic [`FC_ERR_BITS-1:0] err_t;

	typedef enum logic [1:0]
	{
		IDLE,
		SEARCH,
		LOCKED
	} align_state_t;

endpackage

/* hdl/frame_check_settings.svh */
`ifndef FRAME_CHECK_SETTINGS_SVH
`define FRAME_CHECK_SETTINGS_SVH

// Enabled blocks compared for each candidate delay.
`define FC_PERIOD_BLOCKS 64

// Candidate delays, which is also the depth of each delay memory.
`define FC_MAX_DELAY 16

// Width of the mismatch counters.
`define FC_ERR_BITS 16

// APB byte offsets of the register bank.
`define FC_ADDR_CONTROL     8'h00
`define FC_ADDR_STATUS      8'h04
`define FC_ADDR_BEST_DELAY  8'h08
`define FC_ADDR_MIN_ERRORS  8'h0C
`define FC_ADDR_LOCK_ERRORS 8'h10

`endif

/* hdl/frame_checker_top.sv */
module frame_checker_top
(
	input  logic                   i_clock,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  frame_check_pkg::data_t i_tx_data,
	input  frame_check_pkg::ctrl_t i_tx_ctrl,
	input  frame_check_pkg::data_t i_rx_data,
	input  frame_check_pkg::ctrl_t i_rx_ctrl,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [7:0]             i_paddr,
	input  logic [31:0]            i_pwdata,
	output logic [31:0]            o_prdata
);
	import frame_check_pkg::*;

	logic   start_pulse;
	logic   clear_lock_errors;
	logic   searching;
	logic   locked;
	logic   period_end;
	delay_t cur_delay;
	delay_t best_delay;
	err_t   min_errors;
	err_t   lock_errors;
	data_t  tx_delayed_data;
	ctrl_t  tx_delayed_ctrl;

	shift_memory #(.T_PAYLOAD(data_t)) u_data_memory
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_enable(i_enable),
		.i_data  (i_tx_data),
		.i_delay (cur_delay),
		.o_data  (tx_delayed_data)
	);

	shift_memory #(.T_PAYLOAD(ctrl_t)) u_ctrl_memory
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_enable(i_enable),
		.i_data  (i_tx_ctrl),
		.i_delay (cur_delay),
		.o_data  (tx_delayed_ctrl)
	);

	period_timer u_period_timer
	(
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_run       (searching),
		.i_enable    (i_enable),
		.o_period_end(period_end)
	);

	align_fsm u_align_fsm
	(
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_start     (start_pulse),
		.i_period_end(period_end),
		.i_best_delay(best_delay),
		.o_cur_delay (cur_delay),
		.o_searching (searching),
		.o_locked    (locked)
	);

	error_tracker u_error_tracker
	(
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_enable         (i_enable),
		.i_searching      (searching),
		.i_locked         (locked),
		.i_period_end     (period_end),
		.i_clear_lock     (clear_lock_errors),
		.i_cur_delay      (cur_delay),
		.i_rx_data        (i_rx_data),
		.i_tx_delayed_data(tx_delayed_data),
		.i_rx_ctrl        (i_rx_ctrl),
		.i_tx_delayed_ctrl(tx_delayed_ctrl),
		.o_best_delay     (best_delay),
		.o_min_errors     (min_errors),
		.o_lock_errors    (lock_errors)
	);

	apb_regs u_apb_regs
	(
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.i_searching  (searching),
		.i_locked     (locked),
		.i_best_delay (best_delay),
		.i_min_errors (min_errors),
		.i_lock_errors(lock_errors),
		.o_start      (start_pulse),
		.o_clear_lock (clear_lock_errors)
	);

endmodule

/* hdl/period_timer.sv */
`include "frame_check_settings.svh"

module period_timer
(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_run,
	input  logic i_enable,
	output logic o_period_end
);

	localparam int CNT_BITS = $clog2(`FC_PERIOD_BLOCKS);

	logic [CNT_BITS-1:0] block_count;

	// High on the enabled block that completes the period.
	assign o_period_end = i_run && i_enable &&
		(block_count == CNT_BITS'(`FC_PERIOD_BLOCKS - 1));

	always_ff @(posedge i_clock)
	begin
		if (i_reset || !i_run)
			block_count <= '0; // A new search always begins on a whole period.
		else if (i_enable)
		begin
			if (o_period_end)
				block_count <= '0;
			else
				block_count <= block_count + 1'b1;
		end
	end

endmodule

/* hdl/shift_memory.sv */
`include "frame_check_settings.svh"

module shift_memory
#(
	parameter type T_PAYLOAD = frame_check_pkg::data_t
)
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_enable,
	input  T_PAYLOAD                i_data,
	input  frame_check_pkg::delay_t i_delay,
	output T_PAYLOAD                o_data
);
	import frame_check_pkg::*;

	T_PAYLOAD mem [`FC_MAX_DELAY];
	delay_t   wr_ptr;
	delay_t   rd_ptr;

	// Entry written i_delay blocks ago, wrapping around the ring.
	always_comb
	begin
		if (wr_ptr >= i_delay)
			rd_ptr = wr_ptr - i_delay;
		else
			rd_ptr = delay_t'(wr_ptr + `FC_MAX_DELAY - i_delay);
	end

	assign o_data = (i_delay == '0) ? i_data : mem[rd_ptr]; // Zero delay is the live block.

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			wr_ptr <= '0;
			for (int i = 0; i < `FC_MAX_DELAY; i++)
				mem[i] <= '0;
		end
		else if (i_enable)
		begin
			mem[wr_ptr] <= i_data;
			if (wr_ptr == delay_t'(`FC_MAX_DELAY - 1))
				wr_ptr <= '0;
			else
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

endmodule

/* sim.f */
+incdir+hdl
hdl/frame_check_pkg.sv
hdl/shift_memory.sv
hdl/period_timer.sv
hdl/align_fsm.sv
hdl/error_tracker.sv
hdl/apb_regs.sv
hdl/frame_checker_top.sv
tb/tb_frame_checker.sv

/* tb/tb_frame_checker.sv */
`include "frame_check_settings.svh"

module tb_frame_checker;
	import frame_check_pkg::*;

	localparam int CLOCK_PERIOD    = 8;
	localparam int TEST_COUNT      = 6;
	localparam int CYCLES_PER_TEST = 4 * `FC_MAX_DELAY * `FC_PERIOD_BLOCKS * 2;

	logic        i_clock;
	logic        i_reset;
	logic        i_enable;
	data_t       i_tx_data;
	ctrl_t       i_tx_ctrl;
	data_t       i_rx_data;
	ctrl_t       i_rx_ctrl;
	logic        i_psel;
	logic        i_penable;
	logic        i_pwrite;
	logic [7:0]  i_paddr;
	logic [31:0] i_pwdata;
	logic [31:0] o_prdata;

	integer seed;
	bit     stream_on;
	bit     corrupt_ctrl;
	int     corrupt_rate;
	int     corrupt_left;
	int     search_base;
	delay_t lag;
	delay_t first_lag;
	data_t  tx_data_q[$];
	ctrl_t  tx_ctrl_q[$];
	data_t  rx_data_q[$];
	ctrl_t  rx_ctrl_q[$];

	frame_checker_top uut
	(
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (i_enable),
		.i_tx_data(i_tx_data),
		.i_tx_ctrl(i_tx_ctrl),
		.i_rx_data(i_rx_data),
		.i_rx_ctrl(i_rx_ctrl),
		.i_psel   (i_psel),
		.i_penable(i_penable),
		.i_pwrite (i_pwrite),
		.i_paddr  (i_paddr),
		.i_pwdata (i_pwdata),
		.o_prdata (o_prdata)
	);

	always #(CLOCK_PERIOD / 2) i_clock = ~i_clock;

	// Blocks sent before reset history began read as zero, like the cleared delay memories.
	function automatic data_t tx_data_at(input int k);
		return (k < 0) ? '0 : tx_data_q[k];
	endfunction

	function automatic ctrl_t tx_ctrl_at(input int k);
		return (k < 0) ? '0 : tx_ctrl_q[k];
	endfunction

	// Sweeps every candidate delay over its own period, starting at block index base.
	function automatic void sweep_reference(input int base, output delay_t best, output err_t min_err);
		int count;
		int n;
		best    = '0;
		min_err = '1;
		for (int d = 0; d < `FC_MAX_DELAY; d++)
		begin
			count = 0;
			for (int i = 0; i < `FC_PERIOD_BLOCKS; i++)
			begin
				n = base + d * `FC_PERIOD_BLOCKS + i;
				if (rx_data_q[n] != tx_data_at(n - d) || rx_ctrl_q[n] != tx_ctrl_at(n - d))
					count++;
			end
			if (count < int'(min_err)) // A tie keeps the earlier delay.
			begin
				best    = delay_t'(d);
				min_err = err_t'(count);
			end
		end
	endfunction

	task automatic check_delay(input string name, input delay_t got, input delay_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_errors(input string name, input err_t got, input err_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_flags(input string name, input logic got_locked, input logic got_searching,
		input logic exp_locked, input logic exp_searching);
		if ({got_searching, got_locked} !== {exp_searching, exp_locked})
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, {got_searching, got_locked},
				{exp_searching, exp_locked});
			$display("RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// One stream cycle. The receive side is the transmit history at the current lag.
	task automatic drive_stream();
		data_t rx_data;
		ctrl_t rx_ctrl;
		int    n;
		i_tx_data = {$random(seed), $random(seed)};
		i_tx_ctrl = ctrl_t'($random(seed));
		if (!stream_on || ($unsigned($random(seed)) % 4) == 0)
		begin
			i_enable  = 1'b0;
			i_rx_data = {$random(seed), $random(seed)}; // Junk that must be ignored.
			i_rx_ctrl = ctrl_t'($random(seed));
		end
		else
		begin
			n = tx_data_q.size();
			tx_data_q.push_back(i_tx_data);
			tx_ctrl_q.push_back(i_tx_ctrl);
			rx_data = tx_data_at(n - int'(lag));
			rx_ctrl = tx_ctrl_at(n - int'(lag));
			if (corrupt_left > 0 ||
				(corrupt_rate > 0 && ($unsigned($random(seed)) % corrupt_rate) == 0))
			begin
				if (corrupt_ctrl)
					rx_ctrl ^= 8'd1 << ($unsigned($random(seed)) % 8);
				else
					rx_data ^= 64'd1 << ($unsigned($random(seed)) % 64);
				if (corrupt_left > 0)
					corrupt_left--;
			end
			i_enable  = 1'b1;
			i_rx_data = rx_data;
			i_rx_ctrl = rx_ctrl;
			rx_data_q.push_back(rx_data);
			rx_ctrl_q.push_back(rx_ctrl);
		end
	endtask

	task automatic tick();
		@(posedge i_clock);
		#1;
		drive_stream();
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		tick();
		i_psel   = 1'b1;
		i_pwrite = 1'b1;
		i_paddr  = addr;
		i_pwdata = data;
		tick();
		i_penable = 1'b1;
		tick();
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		tick();
		i_psel  = 1'b1;
		i_paddr = addr;
		tick();
		i_penable = 1'b1;
		@(negedge i_clock);
		data = o_prdata;
		tick();
		i_psel    = 1'b0;
		i_penable = 1'b0;
	endtask

	// The stream pauses around the start write, so the first searched block is known exactly.
	task automatic run_search(input delay_t new_lag, input int rate, input bit on_ctrl);
		logic [31:0] status;
		stream_on = 1'b0;
		apb_write(`FC_ADDR_CONTROL, 32'h1);
		lag          = new_lag;
		corrupt_rate = rate;
		corrupt_ctrl = on_ctrl;
		search_base  = rx_data_q.size();
		stream_on    = 1'b1;
		apb_read(`FC_ADDR_STATUS, status);
		check_flags("STATUS", status[0], status[1], 1'b0, 1'b1);
		while (status[0] !== 1'b1)
			apb_read(`FC_ADDR_STATUS, status);
		check_flags("STATUS", status[0], status[1], 1'b1, 1'b0);
		corrupt_rate = 0;
	endtask

	task automatic check_search(input bit clean);
		logic [31:0] rdata;
		delay_t      exp_delay;
		err_t        exp_min;
		sweep_reference(search_base, exp_delay, exp_min);
		apb_read(`FC_ADDR_BEST_DELAY, rdata);
		check_delay("BEST_DELAY", delay_t'(rdata), exp_delay);
		if (clean)
			check_delay("BEST_DELAY", delay_t'(rdata), lag);
		apb_read(`FC_ADDR_MIN_ERRORS, rdata);
		check_errors("MIN_ERRORS", err_t'(rdata), exp_min);
		if (clean)
			check_errors("MIN_ERRORS", err_t'(rdata), '0);
	endtask

	task automatic check_lock_errors(input int count, input bit on_ctrl);
		logic [31:0] rdata;
		corrupt_ctrl = on_ctrl;
		corrupt_left = count;
		while (corrupt_left > 0)
			tick();
		apb_read(`FC_ADDR_LOCK_ERRORS, rdata);
		check_errors("LOCK_ERRORS", err_t'(rdata), err_t'(count));
		apb_write(`FC_ADDR_LOCK_ERRORS, 32'h0);
		apb_read(`FC_ADDR_LOCK_ERRORS, rdata);
		check_errors("LOCK_ERRORS", err_t'(rdata), '0);
	endtask

	initial
	begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLOCK_PERIOD);
		$display("Timeout: the checker gave no result within %0d clock cycles.",
			TEST_COUNT * CYCLES_PER_TEST);
		$display("RESULT: FAIL");
		$fatal(1);
	end

	initial
	begin
		logic [31:0] rdata;
		seed         = 32'hc698;
		i_clock      = 1'b0;
		i_reset      = 1'b1;
		i_enable     = 1'b0;
		i_tx_data    = '0;
		i_tx_ctrl    = '0;
		i_rx_data    = '0;
		i_rx_ctrl    = '0;
		i_psel       = 1'b0;
		i_penable    = 1'b0;
		i_pwrite     = 1'b0;
		i_paddr      = '0;
		i_pwdata     = '0;
		stream_on    = 1'b0;
		corrupt_ctrl = 1'b0;
		corrupt_rate = 0;
		corrupt_left = 0;
		lag          = '0;
		repeat (5) @(posedge i_clock);
		#1;
		i_reset = 1'b0;

		apb_read(`FC_ADDR_STATUS, rdata);
		check_flags("STATUS", rdata[0], rdata[1], 1'b0, 1'b0);
		apb_read(`FC_ADDR_BEST_DELAY, rdata);
		check_delay("BEST_DELAY", delay_t'(rdata), '0);
		apb_read(`FC_ADDR_MIN_ERRORS, rdata);
		check_errors("MIN_ERRORS", err_t'(rdata), '1);
		apb_read(`FC_ADDR_LOCK_ERRORS, rdata);
		check_errors("LOCK_ERRORS", err_t'(rdata), '0);

		stream_on = 1'b1;
		repeat (40) tick();

		first_lag = delay_t'($unsigned($random(seed)) % `FC_MAX_DELAY);
		run_search(first_lag, 0, 1'b0);
		check_search(1'b1);
		check_lock_errors(5, 1'b0);
		check_lock_errors(3, 1'b1);

		run_search(delay_t'($unsigned($random(seed)) % `FC_MAX_DELAY), 8, 1'b0);
		check_search(1'b0);

		// Every block corrupted, so all delays tie and the smallest one must win.
		run_search(delay_t'($unsigned($random(seed)) % `FC_MAX_DELAY), 1, 1'b1);
		check_search(1'b0);

		// Restart from lock at a lag that differs from the first one.
		run_search(delay_t'(first_lag + 1 + ($unsigned($random(seed)) % (`FC_MAX_DELAY - 1))),
			0, 1'b0);
		check_search(1'b1);

		$display("RESULT: PASS");
		$finish;
	end

endmodule
